// ==== files.f ====
rtl/ca_flit_pkg.sv
rtl/ca_msg_pkg.sv
rtl/req_upload.sv
rtl/out_req_arbiter.sv
rtl/ic_download.sv
rtl/commu_assist.sv
tb/commu_assist_props.sv
tb/commu_assist_tb.sv

// ==== rtl/ca_flit_pkg.sv ====
////////////////////////////////////////
// link level, flit and frame code
////////////////////////////////////////

package ca_flit_pkg;

  // one flit on the req/rep fifos
  parameter int flit_w = 16;

  // frame code next to every flit
  parameter int ctrl_w = 2;

  ////////////////////////////////////////
  // frame codes
  ////////////////////////////////////////

  // no flit on the wire
  localparam logic [ctrl_w-1:0] ctrl_none = 2'b00;

  // first flit of a msg, carries the head word
  localparam logic [ctrl_w-1:0] ctrl_head = 2'b01;

  // any middle flit
  localparam logic [ctrl_w-1:0] ctrl_body = 2'b10;

  // last flit, closes the msg on the link
  localparam logic [ctrl_w-1:0] ctrl_tail = 2'b11;

  // a reply line on IN_rep uses the same codes,
  // only the head is looked at by the inst download fsm

endpackage

// ==== rtl/ca_msg_pkg.sv ====
////////////////////////////////////////
// message level, requests and lines
////////////////////////////////////////

package ca_msg_pkg;

  // request msg, head word plus 32 bit addr
  parameter int req_msg_w = 48;

  // flits per request msg
  parameter int req_flits = 3;

  // one request msg, seen two ways
  typedef union packed {
    // slot 2 head (sent first), slot 1 addrhi, slot 0 addrlo
    logic [req_flits-1:0][ca_flit_pkg::flit_w-1:0] flits;
    // head word and full address, used to build msgs
    struct packed {
      logic [ca_flit_pkg::flit_w-1:0]           head;
      logic [req_msg_w-ca_flit_pkg::flit_w-1:0] addr;
    } word;
  } req_msg_u;

  ////////////////////////////////////////
  // inst reply line
  ////////////////////////////////////////

  // data flits after the head, 8 x 16 = one 128 bit line
  parameter int inst_flits_dflt = 8;

endpackage

// ==== rtl/commu_assist.sv ====
module commu_assist
#(
  parameter int inst_flits = ca_msg_pkg::inst_flits_dflt
)
(
  input  logic                                      clk,
  input  logic                                      arst_n,

  // data cache request
  input  logic                                      v_dcache_dc_req,
  input  ca_msg_pkg::req_msg_u                      dcache_dc_req,
  output logic                                      dc_req_fsm_state,   // 1 while uploading

  // local mem request
  input  logic                                      v_mem_m_req,
  input  ca_msg_pkg::req_msg_u                      mem_m_req,
  output logic                                      m_req_fsm_state,

  // OUT_req fifo
  input  logic                                      OUT_req_rdy,
  output logic                                      OUT_req_ack,        // enq strobe
  output logic [ca_flit_pkg::flit_w-1:0]            OUT_req_flit,
  output logic [ca_flit_pkg::ctrl_w-1:0]            OUT_req_ctrl,

  // IN_rep fifo, every flit goes to ic_download
  input  logic                                      rep_rdy,
  input  logic [ca_flit_pkg::flit_w-1:0]            rep_flit_in,
  input  logic [ca_flit_pkg::ctrl_w-1:0]            rep_ctrl_in,
  output logic                                      ack_rep,            // deq strobe

  // inst cache
  output logic [1:0]                                ic_download_fsm_state,
  output logic [ca_flit_pkg::flit_w*inst_flits-1:0] inst_data,
  output logic                                      v_inst_rep
);

  ////////////////////////////////////////
  // uploader to arbiter nets
  ////////////////////////////////////////

  // dc_req path
  logic                            v_dc_req_flit;
  logic [ca_flit_pkg::flit_w-1:0]  dc_req_flit;
  logic [ca_flit_pkg::ctrl_w-1:0]  dc_req_ctrl;
  logic                            ack_dc_req;

  // m_req path
  logic                            v_m_req_flit;
  logic [ca_flit_pkg::flit_w-1:0]  m_req_flit;
  logic [ca_flit_pkg::ctrl_w-1:0]  m_req_ctrl;
  logic                            ack_m_req;

  ////////////////////////////////////////
  // request uploaders
  ////////////////////////////////////////

  req_upload u_dc_req
  (
    .clk    (clk),
    .arst_n (arst_n),
    .v_msg  (v_dcache_dc_req),    // from data cache
    .msg    (dcache_dc_req),
    .ack    (ack_dc_req),         // from arbiter
    .v_flit (v_dc_req_flit),
    .flit   (dc_req_flit),
    .ctrl   (dc_req_ctrl),
    .busy   (dc_req_fsm_state)    // back to data cache
  );

  req_upload u_m_req
  (
    .clk    (clk),
    .arst_n (arst_n),
    .v_msg  (v_mem_m_req),        // from local mem
    .msg    (mem_m_req),
    .ack    (ack_m_req),
    .v_flit (v_m_req_flit),
    .flit   (m_req_flit),
    .ctrl   (m_req_ctrl),
    .busy   (m_req_fsm_state)     // back to mem
  );

  ////////////////////////////////////////
  // OUT_req arbiter and mux
  ////////////////////////////////////////

  out_req_arbiter u_out_req_arbiter
  (
    .clk      (clk),
    .arst_n   (arst_n),
    .v_dc     (v_dc_req_flit),
    .v_mem    (v_m_req_flit),
    .dc_flit  (dc_req_flit),
    .mem_flit (m_req_flit),
    .dc_ctrl  (dc_req_ctrl),
    .mem_ctrl (m_req_ctrl),
    .out_rdy  (OUT_req_rdy),
    .out_ack  (OUT_req_ack),
    .ack_dc   (ack_dc_req),
    .ack_mem  (ack_m_req),
    .out_flit (OUT_req_flit),
    .out_ctrl (OUT_req_ctrl)
  );

  ////////////////////////////////////////
  // inst reply download
  ////////////////////////////////////////

  ic_download
  #(
    .inst_flits (inst_flits)
  )
  u_ic_download
  (
    .clk               (clk),
    .arst_n            (arst_n),
    .rep_rdy           (rep_rdy),
    .rep_flit          (rep_flit_in),
    .rep_ctrl          (rep_ctrl_in),
    .ack_rep           (ack_rep),
    .ic_download_state (ic_download_fsm_state),
    .inst_data         (inst_data),          // to inst cache
    .v_inst_rep        (v_inst_rep)
  );

endmodule

// ==== rtl/ic_download.sv ====
module ic_download
#(
  parameter int inst_flits = 8   // data flits per inst line
)
(
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic                                      rep_rdy,    // IN_rep fifo not empty
  input  logic [ca_flit_pkg::flit_w-1:0]            rep_flit,
  input  logic [ca_flit_pkg::ctrl_w-1:0]            rep_ctrl,
  output logic                                      ack_rep,    // deq strobe to IN_rep fifo
  output logic [1:0]                                ic_download_state,
  output logic [ca_flit_pkg::flit_w*inst_flits-1:0] inst_data,
  output logic                                      v_inst_rep  // line to inst cache
);

  localparam int line_w = ca_flit_pkg::flit_w * inst_flits;
  localparam int cnt_w  = $clog2(inst_flits);

  localparam logic [1:0] st_idle    = 2'b00;
  localparam logic [1:0] st_recv    = 2'b01;
  localparam logic [1:0] st_deliver = 2'b10;

  logic [1:0]        state;
  logic [cnt_w-1:0]  cnt;      // data flits taken so far
  logic [line_w-1:0] line_q;   // shifts in from the low end
  logic              last_flit;

  // no deq while the line sits on the inst cache port
  assign ack_rep   = rep_rdy && (state != st_deliver);
  assign last_flit = (cnt == cnt_w'(inst_flits - 1));

  ////////////////////////////////////////
  // fsm
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= st_idle;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          // stray body/tail flits are eaten here
          if (ack_rep && rep_ctrl == ca_flit_pkg::ctrl_head)
          begin
            state <= st_recv;
            cnt   <= '0;
          end
        end
        st_recv:
        begin
          if (ack_rep)
          begin
            if (last_flit)
            begin
              state <= st_deliver;   // count alone ends the line
              cnt   <= '0;
            end
            else
            begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        st_deliver:
          state <= st_idle;          // one cycle pulse
        default:
          state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // line assembly
  ////////////////////////////////////////

  // first data flit ends up in the top word
  always_ff @(posedge clk)
  begin
    if (state == st_recv && ack_rep)
      line_q <= {line_q[line_w-ca_flit_pkg::flit_w-1:0], rep_flit};
  end

  assign inst_data         = line_q;
  assign v_inst_rep        = (state == st_deliver);
  assign ic_download_state = state;

endmodule

// ==== rtl/out_req_arbiter.sv ====
module out_req_arbiter
(
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              v_dc,      // dc_req uploader
  input  logic                              v_mem,     // m_req uploader
  input  logic [ca_flit_pkg::flit_w-1:0]    dc_flit,
  input  logic [ca_flit_pkg::flit_w-1:0]    mem_flit,
  input  logic [ca_flit_pkg::ctrl_w-1:0]    dc_ctrl,
  input  logic [ca_flit_pkg::ctrl_w-1:0]    mem_ctrl,
  input  logic                              out_rdy,   // OUT_req fifo can take a flit
  output logic                              out_ack,   // enq strobe to OUT_req fifo
  output logic                              ack_dc,
  output logic                              ack_mem,
  output logic [ca_flit_pkg::flit_w-1:0]    out_flit,
  output logic [ca_flit_pkg::ctrl_w-1:0]    out_ctrl
);

  localparam logic src_dc  = 1'b0;
  localparam logic src_mem = 1'b1;

  logic                            lock;          // msg in flight, grant frozen
  logic                            locked_src;
  logic                            last_winner;   // src of the last started msg
  logic                            gnt_src;
  logic                            gnt_v;         // granted src has a flit
  logic [ca_flit_pkg::ctrl_w-1:0]  gnt_ctrl;

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  always_comb
  begin
    if (lock)
      gnt_src = locked_src;            // stay on the msg until its tail
    else if (v_dc && v_mem)
      gnt_src = ~last_winner;          // round robin on a tie
    else if (v_mem)
      gnt_src = src_mem;
    else
      gnt_src = src_dc;                // lone dc, or nobody
  end

  assign gnt_v    = (gnt_src == src_mem) ? v_mem : v_dc;
  assign gnt_ctrl = (gnt_src == src_mem) ? mem_ctrl : dc_ctrl;

  // same cycle path from valid to ack
  assign out_ack = out_rdy && gnt_v;
  assign ack_dc  = out_ack && (gnt_src == src_dc);
  assign ack_mem = out_ack && (gnt_src == src_mem);

  ////////////////////////////////////////
  // msg lock
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      lock        <= 1'b0;
      locked_src  <= src_dc;
      last_winner <= src_mem;          // dc gets the first tie
    end
    else if (out_ack)
    begin
      if (gnt_ctrl == ca_flit_pkg::ctrl_head)
      begin
        lock        <= 1'b1;           // head out, hold this src
        locked_src  <= gnt_src;
        last_winner <= gnt_src;
      end
      else if (gnt_ctrl == ca_flit_pkg::ctrl_tail)
      begin
        lock <= 1'b0;                  // msg done, rearbitrate
      end
    end
  end

  ////////////////////////////////////////
  // OUT_req flit and frame mux
  ////////////////////////////////////////

  always_comb
  begin
    if (!gnt_v)
    begin
      out_flit = '0;                   // idle port
      out_ctrl = ca_flit_pkg::ctrl_none;
    end
    else if (gnt_src == src_mem)
    begin
      out_flit = mem_flit;
      out_ctrl = mem_ctrl;
    end
    else
    begin
      out_flit = dc_flit;
      out_ctrl = dc_ctrl;
    end
  end

endmodule

// ==== rtl/req_upload.sv ====
module req_upload
(
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              v_msg,   // msg from cache or mem
  input  ca_msg_pkg::req_msg_u              msg,
  input  logic                              ack,     // current flit taken by arbiter
  output logic                              v_flit,
  output logic [ca_flit_pkg::flit_w-1:0]    flit,
  output logic [ca_flit_pkg::ctrl_w-1:0]    ctrl,
  output logic                              busy     // fsm state back to the source
);

  localparam int idx_w = $clog2(ca_msg_pkg::req_flits);
  localparam logic [idx_w-1:0] last_idx = idx_w'(ca_msg_pkg::req_flits - 1);

  ca_msg_pkg::req_msg_u msg_q;   // captured msg, payload only
  logic [idx_w-1:0]     idx;     // 0 head .. last_idx tail
  logic [idx_w-1:0]     slot;    // union slot of the current flit
  logic                 busy_q;

  ////////////////////////////////////////
  // capture and flit index
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy_q <= 1'b0;
      idx    <= '0;
    end
    else if (!busy_q)
    begin
      if (v_msg)
      begin
        busy_q <= 1'b1;   // head valid next cycle
        idx    <= '0;
      end
    end
    else if (ack)
    begin
      if (idx == last_idx)
      begin
        busy_q <= 1'b0;   // tail gone, free for next msg
        idx    <= '0;
      end
      else
      begin
        idx <= idx + 1'b1;
      end
    end
  end

  // payload reg, loaded only when idle
  always_ff @(posedge clk)
  begin
    if (!busy_q && v_msg)
      msg_q <= msg;
  end

  ////////////////////////////////////////
  // flit and frame code out
  ////////////////////////////////////////

  assign slot = last_idx - idx;          // head slot goes first
  assign flit = msg_q.flits[slot];

  always_comb
  begin
    if (idx == '0)
      ctrl = ca_flit_pkg::ctrl_head;
    else if (idx == last_idx)
      ctrl = ca_flit_pkg::ctrl_tail;
    else
      ctrl = ca_flit_pkg::ctrl_body;    // addrhi
  end

  assign v_flit = busy_q;   // held until each flit is acked
  assign busy   = busy_q;

endmodule

// ==== tb/commu_assist_props.sv ====
module commu_assist_props
(
  input logic                           clk,
  input logic                           arst_n,
  input logic                           out_rdy,
  input logic                           out_ack,
  input logic                           ack_dc,
  input logic                           ack_mem,
  input logic [ca_flit_pkg::ctrl_w-1:0] out_ctrl,
  input logic                           ack_rep,
  input logic                           v_inst_rep
);

  ////////////////////////////////////////
  // OUT_req side
  ////////////////////////////////////////

  // head, then body, then tail, all from one src
  property msg_in_order(logic ack_s);
    @(posedge clk) disable iff (!arst_n)
      (out_ack && ack_s && out_ctrl == ca_flit_pkg::ctrl_head)
        |=> (out_ack [->1]) ##0 (ack_s && out_ctrl == ca_flit_pkg::ctrl_body)
            ##1 (out_ack [->1]) ##0 (ack_s && out_ctrl == ca_flit_pkg::ctrl_tail);
  endproperty

  // fifo full, frame on the port stays put
  a_hold_without_rdy: assert property (@(posedge clk) disable iff (!arst_n)
    (!out_rdy && out_ctrl != ca_flit_pkg::ctrl_none) |=> out_ctrl == $past(out_ctrl))
    else $error("OUT_req frame code changed while the fifo was not ready");

  a_dc_msg_order: assert property (msg_in_order(ack_dc))
    else $error("dc_req message broken up on OUT_req");

  a_mem_msg_order: assert property (msg_in_order(ack_mem))
    else $error("m_req message broken up on OUT_req");

  ////////////////////////////////////////
  // inst line delivery
  ////////////////////////////////////////

  // pulse right after the last data flit is dequeued, one cycle only
  a_inst_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    v_inst_rep |-> $past(ack_rep) && !$past(v_inst_rep))
    else $error("v_inst_rep without a dequeued flit before it, or held too long");

endmodule

// one checker per target, unused side tied off
bind out_req_arbiter commu_assist_props u_arb_props
(
  .clk        (clk),
  .arst_n     (arst_n),
  .out_rdy    (out_rdy),
  .out_ack    (out_ack),
  .ack_dc     (ack_dc),
  .ack_mem    (ack_mem),
  .out_ctrl   (out_ctrl),
  .ack_rep    (1'b0),
  .v_inst_rep (1'b0)
);

bind ic_download commu_assist_props u_ic_props
(
  .clk        (clk),
  .arst_n     (arst_n),
  .out_rdy    (1'b0),
  .out_ack    (1'b0),
  .ack_dc     (1'b0),
  .ack_mem    (1'b0),
  .out_ctrl   (ca_flit_pkg::ctrl_none),
  .ack_rep    (ack_rep),
  .v_inst_rep (v_inst_rep)
);

// ==== tb/commu_assist_tb.sv ====
module commu_assist_tb;

  localparam int n_words  = ca_msg_pkg::inst_flits_dflt;
  localparam int line_w   = ca_flit_pkg::flit_w * n_words;
  localparam int pair_w   = ca_flit_pkg::ctrl_w + ca_flit_pkg::flit_w;   // {ctrl, flit}
  localparam int max_wait = 500;

  logic clk = 1'b0;
  logic arst_n;
  logic v_dcache_dc_req, v_mem_m_req, OUT_req_rdy, rep_rdy;
  ca_msg_pkg::req_msg_u dcache_dc_req, mem_m_req;
  logic [ca_flit_pkg::flit_w-1:0] rep_flit_in, OUT_req_flit;
  logic [ca_flit_pkg::ctrl_w-1:0] rep_ctrl_in, OUT_req_ctrl;
  logic dc_req_fsm_state, m_req_fsm_state, OUT_req_ack, ack_rep, v_inst_rep;
  logic [1:0] ic_download_fsm_state;
  logic [line_w-1:0] inst_data;

  logic [31:0] seed = 32'he02b_bbd1;
  logic [pair_w-1:0] q_dc[$], q_mem[$];   // expected flits per source
  logic [ca_flit_pkg::flit_w-1:0] line_words[n_words];
  logic [line_w-1:0] exp_line;
  logic tb_lock = 1'b0, tb_src = 1'b0, tb_last = 1'b1;   // dc wins the first tie
  logic rdy_rand;
  int lines_exp = 0, lines_got = 0;

  commu_assist uut (.*);

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function automatic ca_msg_pkg::req_msg_u rand_msg();
    ca_msg_pkg::req_msg_u m;
    logic [31:0] r;
    r = next_rand();
    m.word.head = r[15:0];
    m.word.addr = next_rand();
    return m;
  endfunction

  // msg to flit i: head word, addr high half, addr low half
  function automatic logic [pair_w-1:0] ref_flit(input ca_msg_pkg::req_msg_u m, input int i);
    if (i == 0)
      return {ca_flit_pkg::ctrl_head, m.word.head};
    else if (i == 1)
      return {ca_flit_pkg::ctrl_body, m.word.addr[31:16]};
    else
      return {ca_flit_pkg::ctrl_tail, m.word.addr[15:0]};
  endfunction

  // first data flit lands in the top word
  function automatic logic [line_w-1:0] ref_line();
    logic [line_w-1:0] l;
    for (int k = 0; k < n_words; k++)
      l[(n_words-1-k)*ca_flit_pkg::flit_w +: ca_flit_pkg::flit_w] = line_words[k];
    return l;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_state(input logic [1:0] got, input logic [1:0] exp, input string what);
    if (got !== exp)
      abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_flit(input logic [ca_flit_pkg::flit_w-1:0] got_f,
                            input logic [ca_flit_pkg::ctrl_w-1:0] got_c,
                            input logic [pair_w-1:0] exp_p);
    if (got_f !== exp_p[ca_flit_pkg::flit_w-1:0] || got_c !== exp_p[pair_w-1 -: 2])
      abort_run($sformatf("Mismatch at %0t: OUT_req flit %h/%b expected %h/%b", $time,
                          got_f, got_c, exp_p[ca_flit_pkg::flit_w-1:0], exp_p[pair_w-1 -: 2]));
  endtask

  task automatic check_inst(input logic [line_w-1:0] got, input logic [line_w-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch at %0t: inst_data %h expected %h", $time, got, exp));
  endtask

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  task automatic send_req(input logic to_mem, input ca_msg_pkg::req_msg_u m);
    int n;
    n = 0;
    @(posedge clk);
    while (to_mem ? m_req_fsm_state : dc_req_fsm_state)   // source waits for idle
    begin
      n++;
      if (n > max_wait)
        abort_run("timeout: request uploader never went idle");
      @(posedge clk);
    end
    if (to_mem)
    begin
      v_mem_m_req <= 1'b1;
      mem_m_req   <= m;
    end
    else
    begin
      v_dcache_dc_req <= 1'b1;
      dcache_dc_req   <= m;
    end
    @(posedge clk);
    if (to_mem)
      v_mem_m_req <= 1'b0;
    else
      v_dcache_dc_req <= 1'b0;
  endtask

  task automatic burst(input logic to_mem, input int cnt);
    repeat (cnt) send_req(to_mem, rand_msg());
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while (q_dc.size() != 0 || q_mem.size() != 0)
    begin
      n++;
      if (n > max_wait)
        abort_run("timeout: request flits still pending on OUT_req");
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // hold one IN_rep flit until it is dequeued
  task automatic put_rep(input logic [15:0] f, input logic [1:0] c);
    int n;
    logic [31:0] r;
    n = 0;
    r = next_rand();
    rep_flit_in <= f;
    rep_ctrl_in <= c;
    rep_rdy     <= r[0];
    @(posedge clk);
    while (!ack_rep)
    begin
      n++;
      if (n > max_wait)
        abort_run("timeout: IN_rep flit was never dequeued");
      r = next_rand();
      rep_rdy <= r[0];   // random gaps
      @(posedge clk);
    end
  endtask

  task automatic send_line();
    logic [31:0] r;
    r = next_rand();
    put_rep(r[15:0], ca_flit_pkg::ctrl_body);    // stray flits, dropped while idle
    put_rep(r[31:16], ca_flit_pkg::ctrl_tail);
    for (int k = 0; k < n_words; k++)
    begin
      r = next_rand();
      line_words[k] = r[15:0];
    end
    exp_line = ref_line();
    lines_exp++;
    put_rep(r[31:16], ca_flit_pkg::ctrl_head);
    for (int k = 0; k < n_words; k++)
      put_rep(line_words[k], (k == n_words-1) ? ca_flit_pkg::ctrl_tail : ca_flit_pkg::ctrl_body);
    // next flit already waiting, must sit out the deliver cycle
    rep_flit_in <= r[15:0];
    rep_ctrl_in <= ca_flit_pkg::ctrl_none;
    rep_rdy     <= 1'b1;
    @(posedge clk);
    rep_rdy <= 1'b0;
  endtask

  task automatic wait_line();
    int n;
    n = 0;
    @(negedge clk);
    while (lines_got != lines_exp)
    begin
      n++;
      if (n > max_wait)
        abort_run("timeout: v_inst_rep never came");
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  ////////////////////////////////////////
  // ready driver and compare
  ////////////////////////////////////////

  always @(posedge clk)
  begin : drive_rdy
    logic [31:0] r;
    if (arst_n)
    begin
      r = next_rand();
      OUT_req_rdy <= rdy_rand ? r[0] : 1'b1;
    end
  end

  always @(posedge clk)
  begin : compare
    logic [pair_w-1:0] exp_p;
    if (arst_n)
    begin
      check_bit(dc_req_fsm_state, q_dc.size() != 0, "dc_req_fsm_state");
      check_bit(m_req_fsm_state, q_mem.size() != 0, "m_req_fsm_state");
      check_bit(OUT_req_ack, OUT_req_rdy && (q_dc.size() != 0 || q_mem.size() != 0),
                "OUT_req_ack");
      if (OUT_req_ack)
      begin
        if (!tb_lock)
        begin
          // round robin on a tie, else the lone source
          tb_src  = (q_dc.size() != 0 && q_mem.size() != 0) ? !tb_last : (q_mem.size() != 0);
          tb_last = tb_src;
          tb_lock = 1'b1;
        end
        if (tb_src ? q_mem.size() == 0 : q_dc.size() == 0)
          abort_run("OUT_req took a flit that no source had pending");
        exp_p = tb_src ? q_mem.pop_front() : q_dc.pop_front();
        check_flit(OUT_req_flit, OUT_req_ctrl, exp_p);
        if (exp_p[pair_w-1 -: 2] == ca_flit_pkg::ctrl_tail)
          tb_lock = 1'b0;
      end
      // capture edge, queue the whole msg
      if (v_dcache_dc_req && !dc_req_fsm_state)
        for (int i = 0; i < ca_msg_pkg::req_flits; i++)
          q_dc.push_back(ref_flit(dcache_dc_req, i));
      if (v_mem_m_req && !m_req_fsm_state)
        for (int i = 0; i < ca_msg_pkg::req_flits; i++)
          q_mem.push_back(ref_flit(mem_m_req, i));
      if (v_inst_rep)
      begin
        check_inst(inst_data, exp_line);
        check_bit(ack_rep, 1'b0, "ack_rep in the deliver cycle");
        check_state(ic_download_fsm_state, 2'b10, "ic_download_fsm_state in deliver");
        lines_got++;
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    arst_n          = 1'b0;
    v_dcache_dc_req = 1'b0;
    dcache_dc_req   = '0;
    v_mem_m_req     = 1'b0;
    mem_m_req       = '0;
    OUT_req_rdy     = 1'b1;
    rep_rdy         = 1'b0;
    rep_flit_in     = '0;
    rep_ctrl_in     = ca_flit_pkg::ctrl_none;
    rdy_rand        = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_bit(OUT_req_ack, 1'b0, "OUT_req_ack after reset");
    check_bit(ack_rep, 1'b0, "ack_rep after reset");
    check_bit(v_inst_rep, 1'b0, "v_inst_rep after reset");
    check_bit(dc_req_fsm_state, 1'b0, "dc_req_fsm_state after reset");
    check_bit(m_req_fsm_state, 1'b0, "m_req_fsm_state after reset");
    check_state(ic_download_fsm_state, 2'b00, "ic_download_fsm_state after reset");
    @(posedge clk);
    send_req(1'b0, rand_msg());   // lone dc msg
    wait_drain();
    fork
      burst(1'b0, 4);
      burst(1'b1, 4);
    join
    wait_drain();
    rdy_rand <= 1'b1;             // OUT_req back-pressure
    fork
      burst(1'b0, 6);
      burst(1'b1, 6);
    join
    wait_drain();
    rdy_rand <= 1'b0;
    burst(1'b1, 5);               // back to back, one source
    wait_drain();
    send_line();
    wait_line();
    send_line();
    wait_line();
    repeat (3) @(posedge clk);
    if (q_dc.size() == 0 && q_mem.size() == 0 && lines_got == lines_exp)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
      abort_run("run ended with flits or lines still outstanding");
  end

endmodule
